// ==== logic/setup_pkg.sv ====
// Kernel setup shared definitions
// Address, count and response widths used across the setup block,
// along with the cache-line stride of the read engine

package setup_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    // Byte address of the graph array
    parameter int ADDR_WIDTH = 32;

    // Length of a job in cache lines
    parameter int COUNT_WIDTH = 16;

    // One memory response word
    parameter int RESP_WIDTH = 64;

    // ----------------------------------------------------------------------
    // Memory geometry
    // ----------------------------------------------------------------------
    // Stride between consecutive read requests
    parameter int CACHE_LINE_BYTES = 64;

    // ----------------------------------------------------------------------
    // Types
    // ----------------------------------------------------------------------
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    typedef logic [COUNT_WIDTH-1:0] count_t;

    typedef logic [RESP_WIDTH-1:0] resp_data_t;

endpackage : setup_pkg

// ==== logic/sync_fifo.sv ====
// Synchronous FIFO
// Circular buffer with an occupancy count, a registered read port and
// empty, full and programmable-full flags taken from the count

module sync_fifo #(
    parameter int WIDTH           = 32,
    parameter int DEPTH           = 16,
    parameter int PROG_FULL_LEVEL = 12
) (
    input  logic             ap_clk,
    input  logic             setup_areset,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 do_wr;
    logic                 do_rd;

    // Pointer advance with wrap at the last entry
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // ----------------------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            valid <= do_rd;
        end
    end

    // Storage and registered read data
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

    assign empty     = (count == '0);
    assign full      = (count == CNT_WIDTH'(DEPTH));
    assign prog_full = (count >= CNT_WIDTH'(PROG_FULL_LEVEL));

    // Both sides must respect the flags they were given
    assert property (@(posedge ap_clk) disable iff (setup_areset) wr_en |-> !full)
        else $error("sync_fifo: write while full");

    assert property (@(posedge ap_clk) disable iff (setup_areset) rd_en |-> !empty)
        else $error("sync_fifo: read while empty");

endmodule : sync_fifo

// ==== logic/serial_read_engine.sv ====
// Serial read engine
// Turns a base address and a cache-line count into a run of request
// addresses, one per cycle, each one cache line past the previous,
// holding off while the request FIFO is above its threshold

module serial_read_engine import setup_pkg::*; (
    input  logic   ap_clk,
    input  logic   setup_areset,
    input  logic   start,
    input  addr_t  base,
    input  count_t lines,
    input  logic   pause,
    output logic   busy,
    output logic   req_wr_en,
    output addr_t  req_addr
);

    addr_t  addr_q;
    count_t remaining;
    logic   issue;

    // ----------------------------------------------------------------------
    // Request issue
    // ----------------------------------------------------------------------
    // One write per cycle unless the FIFO threshold is reached
    assign issue     = busy && !pause;
    assign req_wr_en = issue;
    assign req_addr  = addr_q;

    // ----------------------------------------------------------------------
    // Line counter and busy flag
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            remaining <= '0;
            busy      <= 1'b0;
        end else if (start) begin
            remaining <= lines;
            // A zero-line job never goes busy
            busy      <= (lines != '0);
        end else if (issue) begin
            remaining <= remaining - count_t'(1);
            if (remaining == count_t'(1)) begin
                busy <= 1'b0;
            end
        end
    end

    // Address register, payload only
    always_ff @(posedge ap_clk) begin
        if (start) begin
            addr_q <= base;
        end else if (issue) begin
            addr_q <= addr_q + addr_t'(CACHE_LINE_BYTES);
        end
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    // The control FSM only starts a job once the previous one has drained
    assert property (@(posedge ap_clk) disable iff (setup_areset) start |-> !busy)
        else $error("serial_read_engine: start while busy");

endmodule : serial_read_engine

// ==== logic/setup_control.sv ====
// Kernel setup control
// Captures the host descriptor, starts the read engine and raises the
// four-phase acknowledge once all requests have left the request FIFO

module setup_control import setup_pkg::*; (
    input  logic   ap_clk,
    input  logic   setup_areset,
    input  logic   desc_req,
    input  addr_t  desc_base,
    input  count_t desc_lines,
    output logic   desc_ack,
    output logic   eng_start,
    output addr_t  eng_base,
    output count_t eng_lines,
    input  logic   eng_busy,
    input  logic   req_fifo_empty
);

    typedef enum logic [2:0] {
        RESET,
        IDLE,
        REQ_START,
        REQ_BUSY,
        REQ_DONE
    } setup_state_t;

    setup_state_t state;
    setup_state_t next_state;
    logic         desc_req_q;

    // ----------------------------------------------------------------------
    // Descriptor capture
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            desc_req_q <= 1'b0;
        end else begin
            desc_req_q <= desc_req;
        end
    end

    // Fields are frozen once the job leaves IDLE
    always_ff @(posedge ap_clk) begin
        if (state == IDLE) begin
            eng_base  <= desc_base;
            eng_lines <= desc_lines;
        end
    end

    // ----------------------------------------------------------------------
    // Setup FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET: begin
                next_state = IDLE;
            end
            IDLE: begin
                if (desc_req_q && !eng_busy) begin
                    next_state = REQ_START;
                end
            end
            REQ_START: begin
                next_state = REQ_BUSY;
            end
            REQ_BUSY: begin
                // Done when every request is generated and drained
                if (!eng_busy && req_fifo_empty) begin
                    next_state = REQ_DONE;
                end
            end
            REQ_DONE: begin
                if (!desc_req_q) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = RESET;
            end
        endcase
    end

    // Registered engine start pulse and acknowledge
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            eng_start <= 1'b0;
            desc_ack  <= 1'b0;
        end else begin
            eng_start <= (next_state == REQ_START);
            desc_ack  <= (next_state == REQ_DONE);
        end
    end

    // Acknowledge is only withdrawn after the request has dropped
    assert property (@(posedge ap_clk) disable iff (setup_areset)
                     $fell(desc_ack) |-> !$past(desc_req))
        else $error("setup_control: desc_ack fell while desc_req high");

endmodule : setup_control

// ==== logic/kernel_setup.sv ====
// Graph overlay kernel setup
// Takes one descriptor per four-phase handshake, streams its cache-line
// read requests through the request FIFO and buffers memory responses
// for the consumer in a separate response FIFO

module kernel_setup import setup_pkg::*; #(
    parameter int REQ_FIFO_DEPTH  = 16,
    parameter int RESP_FIFO_DEPTH = 16
) (
    input  logic       ap_clk,
    input  logic       setup_areset,
    // Descriptor handshake
    input  logic       desc_req,
    input  addr_t      desc_base,
    input  count_t     desc_lines,
    output logic       desc_ack,
    // Request stream to memory
    input  logic       mem_req_rd_en,
    output logic       mem_req_valid,
    output addr_t      mem_req_addr,
    output logic       mem_req_empty,
    // Responses from memory
    input  logic       mem_resp_valid,
    input  resp_data_t mem_resp_data,
    output logic       mem_resp_full,
    // Responses to the consumer
    input  logic       resp_rd_en,
    output logic       resp_valid,
    output resp_data_t resp_data,
    output logic       resp_empty
);

    // Headroom above the threshold for writes already under way
    localparam int REQ_PROG_FULL = REQ_FIFO_DEPTH - 4;

    logic   eng_start;
    addr_t  eng_base;
    count_t eng_lines;
    logic   eng_busy;
    logic   req_wr_en;
    addr_t  req_wr_addr;
    logic   req_prog_full;

    // ----------------------------------------------------------------------
    // Control and read engine
    // ----------------------------------------------------------------------
    setup_control u_control (
        .ap_clk         (ap_clk),
        .setup_areset   (setup_areset),
        .desc_req       (desc_req),
        .desc_base      (desc_base),
        .desc_lines     (desc_lines),
        .desc_ack       (desc_ack),
        .eng_start      (eng_start),
        .eng_base       (eng_base),
        .eng_lines      (eng_lines),
        .eng_busy       (eng_busy),
        .req_fifo_empty (mem_req_empty)
    );

    serial_read_engine u_engine (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .start        (eng_start),
        .base         (eng_base),
        .lines        (eng_lines),
        .pause        (req_prog_full),
        .busy         (eng_busy),
        .req_wr_en    (req_wr_en),
        .req_addr     (req_wr_addr)
    );

    // ----------------------------------------------------------------------
    // Request and response buffers
    // ----------------------------------------------------------------------
    sync_fifo #(
        .WIDTH           (ADDR_WIDTH),
        .DEPTH           (REQ_FIFO_DEPTH),
        .PROG_FULL_LEVEL (REQ_PROG_FULL)
    ) u_req_fifo (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .wr_en        (req_wr_en),
        .din          (req_wr_addr),
        .rd_en        (mem_req_rd_en),
        .dout         (mem_req_addr),
        .valid        (mem_req_valid),
        .empty        (mem_req_empty),
        .full         (),
        .prog_full    (req_prog_full)
    );

    sync_fifo #(
        .WIDTH           (RESP_WIDTH),
        .DEPTH           (RESP_FIFO_DEPTH),
        .PROG_FULL_LEVEL (RESP_FIFO_DEPTH)
    ) u_resp_fifo (
        .ap_clk       (ap_clk),
        .setup_areset (setup_areset),
        .wr_en        (mem_resp_valid),
        .din          (mem_resp_data),
        .rd_en        (resp_rd_en),
        .dout         (resp_data),
        .valid        (resp_valid),
        .empty        (resp_empty),
        .full         (mem_resp_full),
        .prog_full    ()
    );

endmodule : kernel_setup

// ==== tests/kernel_setup_tb.sv ====
// Kernel setup testbench
// Sends random descriptors with and without memory-side back-pressure,
// checks the request stream and the four-phase acknowledge, and pushes
// random response words through the response FIFO

module kernel_setup_tb import setup_pkg::*; ();

    localparam int LINE_BYTES       = 64;
    localparam int FIRST_REQ_CYCLES = 4;
    localparam int WAIT_LIMIT       = 4000;
    localparam int ACK_DROP_LIMIT   = 16;
    localparam int RESP_DEPTH       = 16;

    logic       ap_clk;
    logic       setup_areset;
    logic       desc_req;
    addr_t      desc_base;
    count_t     desc_lines;
    logic       desc_ack;
    logic       mem_req_rd_en;
    logic       mem_req_valid;
    addr_t      mem_req_addr;
    logic       mem_req_empty;
    logic       mem_resp_valid;
    resp_data_t mem_resp_data;
    logic       mem_resp_full;
    logic       resp_rd_en;
    logic       resp_valid;
    resp_data_t resp_data;
    logic       resp_empty;

    // Reference model state
    addr_t       exp_addr_q[$];
    resp_data_t  exp_resp_q[$];
    logic [31:0] rng;
    int          errors;
    int          timeouts;
    int          req_seen;
    int          resp_seen;
    int          hold_cycles;
    int          resp_left;
    logic        backpressure;

    kernel_setup #(
        .REQ_FIFO_DEPTH  (16),
        .RESP_FIFO_DEPTH (RESP_DEPTH)
    ) uut (
        .ap_clk         (ap_clk),
        .setup_areset   (setup_areset),
        .desc_req       (desc_req),
        .desc_base      (desc_base),
        .desc_lines     (desc_lines),
        .desc_ack       (desc_ack),
        .mem_req_rd_en  (mem_req_rd_en),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_empty  (mem_req_empty),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .mem_resp_full  (mem_resp_full),
        .resp_rd_en     (resp_rd_en),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .resp_empty     (resp_empty)
    );

    always #4 ap_clk = ~ap_clk;

    // xorshift32 generator
    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic expect_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // ----------------------------------------------------------------------
    // Sample outputs after each clock edge, then drive the memory side
    // ----------------------------------------------------------------------
    task automatic step();
        logic [31:0] r;
        logic [31:0] lo;
        logic [31:0] hi;
        addr_t       exp_addr;
        resp_data_t  exp_data;
        @(posedge ap_clk);
        #1;
        if (mem_req_valid) begin
            if (exp_addr_q.size() == 0) begin
                errors++;
                $display("ERROR at %0t: unexpected request %h", $time, mem_req_addr);
            end else begin
                exp_addr = exp_addr_q.pop_front();
                req_seen++;
                if (mem_req_addr !== exp_addr) begin
                    errors++;
                    $display("ERROR at %0t: request %h, expected %h",
                             $time, mem_req_addr, exp_addr);
                end
            end
        end
        if (desc_ack && exp_addr_q.size() != 0) begin
            errors++;
            $display("ERROR at %0t: desc_ack high with %0d requests unread",
                     $time, exp_addr_q.size());
        end
        if (resp_valid) begin
            if (exp_resp_q.size() == 0) begin
                errors++;
                $display("ERROR at %0t: unexpected response %h", $time, resp_data);
            end else begin
                exp_data = exp_resp_q.pop_front();
                resp_seen++;
                if (resp_data !== exp_data) begin
                    errors++;
                    $display("ERROR at %0t: response %h, expected %h",
                             $time, resp_data, exp_data);
                end
            end
        end
        // Words written and not yet read are the response FIFO occupancy
        expect_level("mem_resp_full", mem_resp_full, exp_resp_q.size() >= RESP_DEPTH);
        expect_level("resp_empty", resp_empty, exp_resp_q.size() == 0);
        // Request reads with random stalls under back-pressure
        r = next_rand();
        if (hold_cycles != 0) begin
            hold_cycles--;
            mem_req_rd_en = 1'b0;
        end else if (backpressure && r[7:4] == 4'd0) begin
            hold_cycles   = int'(r[12:8]);
            mem_req_rd_en = 1'b0;
        end else begin
            mem_req_rd_en = (r[1:0] != 2'd0) && !mem_req_empty;
        end
        // Response writes respect full and reads run slower so the FIFO fills
        r = next_rand();
        if (resp_left != 0 && !mem_resp_full && r[0]) begin
            lo             = next_rand();
            hi             = next_rand();
            mem_resp_valid = 1'b1;
            mem_resp_data  = {hi, lo};
            exp_resp_q.push_back({hi, lo});
            resp_left--;
        end else begin
            mem_resp_valid = 1'b0;
        end
        resp_rd_en = (r[2:1] == 2'd0) && !resp_empty;
    endtask

    // ----------------------------------------------------------------------
    // One descriptor through the full four-phase handshake
    // ----------------------------------------------------------------------
    task automatic run_job(input addr_t base, input count_t lines);
        int cycles;
        int start_seen;
        int hold;
        if (timeouts != 0) begin
            return;
        end
        for (int i = 0; i < int'(lines); i++) begin
            exp_addr_q.push_back(base + addr_t'(i * LINE_BYTES));
        end
        start_seen = req_seen;
        desc_base  = base;
        desc_lines = lines;
        desc_req   = 1'b1;
        cycles     = 0;
        while (mem_req_empty && !desc_ack && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (lines != '0 && cycles != FIRST_REQ_CYCLES) begin
            errors++;
            $display("ERROR at %0t: first request after %0d cycles, expected %0d",
                     $time, cycles, FIRST_REQ_CYCLES);
        end
        while (!desc_ack && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (!desc_ack) begin
            timeouts++;
            $display("Timed out waiting for desc_ack on a job of %0d lines", lines);
            return;
        end
        if (req_seen - start_seen != int'(lines) || exp_addr_q.size() != 0) begin
            errors++;
            $display("ERROR at %0t: %0d requests seen, expected %0d",
                     $time, req_seen - start_seen, lines);
        end
        // Acknowledge must hold while the request stays up
        hold = int'(next_rand() % 4) + 1;
        repeat (hold) begin
            step();
            expect_level("desc_ack", desc_ack, 1'b1);
        end
        desc_req = 1'b0;
        cycles   = 0;
        while (desc_ack && cycles < ACK_DROP_LIMIT) begin
            step();
            cycles++;
        end
        if (desc_ack) begin
            timeouts++;
            $display("Timed out waiting for desc_ack to fall after desc_req fell");
        end
    endtask

    task automatic random_job();
        logic [31:0] r;
        count_t      lines;
        r     = next_rand();
        lines = count_t'(next_rand() % 40 + 1);
        run_job({r[31:6], 6'd0}, lines);
    endtask

    initial begin
        int cycles;
        ap_clk         = 1'b0;
        setup_areset   = 1'b1;
        desc_req       = 1'b0;
        desc_base      = '0;
        desc_lines     = '0;
        mem_req_rd_en  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        resp_rd_en     = 1'b0;
        rng            = 32'h72aa_69d2;
        errors         = 0;
        timeouts       = 0;
        req_seen       = 0;
        resp_seen      = 0;
        hold_cycles    = 0;
        resp_left      = 0;
        backpressure   = 1'b0;
        repeat (16) @(posedge ap_clk);
        #1;
        setup_areset = 1'b0;

        expect_level("desc_ack", desc_ack, 1'b0);
        expect_level("mem_req_valid", mem_req_valid, 1'b0);
        expect_level("resp_valid", resp_valid, 1'b0);
        expect_level("mem_req_empty", mem_req_empty, 1'b1);
        expect_level("resp_empty", resp_empty, 1'b1);
        repeat (3) step();

        // Free-running memory side
        repeat (6) random_job();

        // Stalled memory side with long jobs that reach the engine threshold
        backpressure = 1'b1;
        repeat (6) random_job();
        run_job(32'h0001_0000, count_t'(40));
        run_job(32'h0002_0040, count_t'(0));
        random_job();
        backpressure = 1'b0;

        // Response stream
        if (timeouts == 0) begin
            resp_left = 80;
            cycles    = 0;
            while ((resp_left != 0 || exp_resp_q.size() != 0) && cycles < WAIT_LIMIT) begin
                step();
                cycles++;
            end
            if (resp_left != 0 || exp_resp_q.size() != 0) begin
                timeouts++;
                $display("Timed out with %0d response words still expected",
                         resp_left + exp_resp_q.size());
            end
        end

        $display("Summary: %0d errors, %0d timeouts, %0d requests, %0d responses checked",
                 errors, timeouts, req_seen, resp_seen);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : kernel_setup_tb

// ==== kernel_setup.f ====
logic/setup_pkg.sv
logic/sync_fifo.sv
logic/serial_read_engine.sv
logic/setup_control.sv
logic/kernel_setup.sv
tests/kernel_setup_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the kernel setup testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f kernel_setup.f \
    --top-module kernel_setup_tb -Mdir obj_dir -o kernel_setup_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/kernel_setup_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation finished: FAIL" sim.log && { echo "Testbench reported failure"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "Simulation ended early"; exit 1; }
exit 0
